// File: Makefile
# Verilator build and run of the lockstep MAC testbench

TOP := tb_lockstep_mac
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f verilog.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_lockstep_mac.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lockstep_mac;

  localparam int Offset  = 2;
  localparam int OpW     = lockstep_pkg::OperandWidth;
  localparam int AccW    = lockstep_pkg::AccWidth;
  // Mismatch history, alert shows a result Offset+1 edges after lane 0
  localparam int PipeLen = Offset + 2;

  localparam int NumRandOps  = 500;
  localparam int NumFreshOps = 300;
  // Ops plus worst case gaps, with room for the directed phases
  localparam int MaxCycles   = 2 * (NumRandOps + NumFreshOps) + 400;

  logic            clk_i;
  logic            rst_ni;
  logic            in_valid_i;
  logic            in_clear_i;
  logic [OpW-1:0]  in_a_i;
  logic [OpW-1:0]  in_b_i;
  logic            fault_inject_i;
  wire             acc_valid_o;
  wire  [AccW-1:0] acc_o;
  wire             alert_major_o;

  // Reference state
  logic [AccW-1:0]    main_acc;
  logic [AccW-1:0]    shadow_acc;
  logic               exp_valid;
  logic [PipeLen-1:0] mismatch_pipe;
  int                 edges_since_reset;
  logic               exp_alert;

  logic [31:0] rng_state   = 32'h7dab_718a;
  int          cycle_count = 0;
  int          alert_cycles = 0;

  lockstep_mac_top #(
    .LockstepOffset (Offset)
  ) dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (in_valid_i),
    .in_clear_i     (in_clear_i),
    .in_a_i         (in_a_i),
    .in_b_i         (in_b_i),
    .fault_inject_i (fault_inject_i),
    .acc_valid_o    (acc_valid_o),
    .acc_o          (acc_o),
    .alert_major_o  (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Clear loads the product, otherwise add and wrap at 2^24
  function automatic logic [AccW-1:0] mac_ref(input logic [AccW-1:0] acc, input logic clear,
                                              input logic [OpW-1:0] a, input logic [OpW-1:0] b);
    logic [AccW-1:0] prod;
    prod = AccW'(a) * AccW'(b);
    if (clear) begin
      return prod;
    end
    return acc + prod;
  endfunction

  task automatic roll_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    stop_with_failure($sformatf("[ERROR] %0t: %s expected 0x%0h, got 0x%0h",
                                $time, name, expected, actual));
  endtask

  task automatic apply_op(input logic valid, input logic clear, input logic [OpW-1:0] a,
                          input logic [OpW-1:0] b, input logic inject);
    @(posedge clk_i);
    in_valid_i     <= valid;
    in_clear_i     <= clear;
    in_a_i         <= a;
    in_b_i         <= b;
    fault_inject_i <= inject;
  endtask

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      apply_op(1'b0, 1'b0, '0, '0, 1'b0);
    end
  endtask

  // Random operands, one gap in four, one clear in sixteen
  task automatic run_random_ops(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      roll_random(r);
      if (r[3:2] == 2'b00) begin
        drive_idle(1);
      end
      apply_op(1'b1, r[7:4] == 4'h0, r[15:8], r[23:16], 1'b0);
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk_i);
    rst_ni         <= 1'b0;
    in_valid_i     <= 1'b0;
    in_clear_i     <= 1'b0;
    in_a_i         <= '0;
    in_b_i         <= '0;
    fault_inject_i <= 1'b0;
    @(negedge clk_i);
    assert (acc_valid_o === 1'b0) else report_value("acc_valid_o", 32'd0, 32'(acc_valid_o));
    assert (acc_o === '0) else report_value("acc_o", 32'd0, 32'(acc_o));
    assert (alert_major_o === 1'b0) else report_value("alert_major_o", 32'd0, 32'(alert_major_o));
    @(posedge clk_i);
    @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Samples the inputs at the same edge as the DUT
  always @(posedge clk_i or negedge rst_ni) begin : reference_model
    logic [AccW-1:0] next_main;
    logic [AccW-1:0] next_shadow;
    if (!rst_ni) begin
      main_acc          <= '0;
      shadow_acc        <= '0;
      exp_valid         <= 1'b0;
      mismatch_pipe     <= '0;
      edges_since_reset <= 0;
    end else begin
      next_main   = main_acc;
      next_shadow = shadow_acc;
      if (in_valid_i) begin
        next_main   = mac_ref(main_acc, in_clear_i, in_a_i, in_b_i);
        next_shadow = mac_ref(shadow_acc, in_clear_i,
                              {in_a_i[OpW-1:1], in_a_i[0] ^ fault_inject_i}, in_b_i);
      end
      main_acc      <= next_main;
      shadow_acc    <= next_shadow;
      exp_valid     <= in_valid_i;
      mismatch_pipe <= {mismatch_pipe[PipeLen-2:0], next_main != next_shadow};
      if (edges_since_reset < Offset + 1) begin
        edges_since_reset <= edges_since_reset + 1;
      end
    end
  end

  // Compare enable turns on Offset+1 edges after reset release
  assign exp_alert = (edges_since_reset >= Offset + 1) && mismatch_pipe[PipeLen-1];

  always @(negedge clk_i) begin : compare_outputs
    assert (acc_valid_o === exp_valid)
      else report_value("acc_valid_o", 32'(exp_valid), 32'(acc_valid_o));
    assert (acc_o === main_acc)
      else report_value("acc_o", 32'(main_acc), 32'(acc_o));
    assert (alert_major_o === exp_alert)
      else report_value("alert_major_o", 32'(exp_alert), 32'(alert_major_o));
    if (alert_major_o === 1'b1) begin
      alert_cycles++;
    end
  end

  always @(posedge clk_i) begin : cycle_limit
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    rst_ni         = 1'b0;
    in_valid_i     = 1'b0;
    in_clear_i     = 1'b0;
    in_a_i         = '0;
    in_b_i         = '0;
    fault_inject_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Random accumulation with no fault, alert must stay low
    run_random_ops(NumRandOps);
    drive_idle(Offset + 3);
    assert (alert_cycles == 0) else stop_with_failure("Alert raised during the clean run");

    // Alert test with b nonzero
    roll_random(r);
    apply_op(1'b1, 1'b1, r[15:8], r[23:16], 1'b0);
    roll_random(r);
    apply_op(1'b1, 1'b0, r[15:8], r[23:16] | 8'h01, 1'b1);
    for (int i = 0; i < 5; i++) begin
      roll_random(r);
      apply_op(1'b1, 1'b0, r[15:8], r[23:16], 1'b0);
    end
    drive_idle(Offset + 3);
    @(negedge clk_i);
    assert (alert_major_o === 1'b1)
      else stop_with_failure("Alert did not rise after the injected operation");
    roll_random(r);
    apply_op(1'b1, 1'b1, r[15:8], r[23:16], 1'b0);
    drive_idle(Offset + 3);
    @(negedge clk_i);
    assert (alert_major_o === 1'b0)
      else stop_with_failure("Alert did not fall after the clean clear operation");

    // Mismatch pending, then reset in the middle of it
    roll_random(r);
    apply_op(1'b1, 1'b0, r[15:8], r[23:16] | 8'h01, 1'b1);
    drive_idle(Offset + 3);
    @(negedge clk_i);
    assert (alert_major_o === 1'b1)
      else stop_with_failure("Alert did not rise before the reset pulse");
    pulse_reset();
    alert_cycles = 0;
    run_random_ops(NumFreshOps);
    drive_idle(Offset + 3);
    assert (alert_cycles == 0) else stop_with_failure("Alert raised after the reset pulse");

    // Flip with b zero gives the same product
    roll_random(r);
    apply_op(1'b1, 1'b0, r[15:8], 8'h00, 1'b1);
    for (int i = 0; i < 4; i++) begin
      roll_random(r);
      apply_op(1'b1, 1'b0, r[15:8], r[23:16], 1'b0);
    end
    drive_idle(Offset + 3);
    assert (alert_cycles == 0) else stop_with_failure("Alert raised by an injection with b zero");

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/lockstep_compare.sv
`timescale 1ns/10ps
`default_nettype none

module lockstep_compare #(
  parameter int LockstepOffset = lockstep_pkg::DefaultLockstepOffset
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  lockstep_pkg::mac_res_t main_res_i,
  input  lockstep_pkg::mac_res_t shadow_res_i,
  input  lockstep_pkg::mubi4_t   cmp_enable_i,
  output logic                   alert_major_o
);

  // Main result waits for the lane offset plus the shadow register
  localparam int MainDelay = LockstepOffset + 1;

  lockstep_pkg::mac_res_t main_res_q;
  lockstep_pkg::mac_res_t shadow_res_q;
  logic                   cmp_on;
  logic                   mismatch;

  ////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////

  lockstep_delay #(
    .Depth     (MainDelay),
    .payload_t (lockstep_pkg::mac_res_t)
  ) u_main_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_res_i),
    .data_o (main_res_q)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_res_q <= '0;
    end else begin
      shadow_res_q <= shadow_res_i;
    end
  end

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  // Any corrupted enable still counts as on
  assign cmp_on   = (cmp_enable_i != lockstep_pkg::MuBi4Off);
  assign mismatch = (main_res_q != shadow_res_q);

  assign alert_major_o = cmp_on & mismatch;

  alert_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o)
  );

endmodule

`default_nettype wire

// File: src/lockstep_delay.sv
`timescale 1ns/10ps
`default_nettype none

module lockstep_delay #(
  parameter int  Depth     = 2,
  parameter type payload_t = logic
) (
  input  wire      clk_i,
  input  wire      rst_ni,
  input  payload_t data_i,
  output payload_t data_o
);

  // Stage 0 takes the input, the last stage drives the output
  payload_t stage_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stage_q[i] <= payload_t'('0);
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

`default_nettype wire

// File: src/lockstep_mac_top.sv
`timescale 1ns/10ps
`default_nettype none

module lockstep_mac_top #(
  parameter int LockstepOffset = lockstep_pkg::DefaultLockstepOffset
) (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  in_valid_i,
  input  wire                                  in_clear_i,
  input  wire  [lockstep_pkg::OperandWidth-1:0] in_a_i,
  input  wire  [lockstep_pkg::OperandWidth-1:0] in_b_i,
  input  wire                                  fault_inject_i,
  output logic                                 acc_valid_o,
  output logic [lockstep_pkg::AccWidth-1:0]     acc_o,
  output logic                                 alert_major_o
);

  localparam int NumLanes = 2;
  localparam int OpW      = lockstep_pkg::OperandWidth;

  logic                   rst_shadow_n;
  lockstep_pkg::mubi4_t   cmp_enable;
  lockstep_pkg::mac_op_t  feed_in;
  lockstep_pkg::mac_op_t  feed_out;
  logic [NumLanes-1:0]    lane_rst_n;
  lockstep_pkg::mac_res_t lane_res [NumLanes];

  ////////////////////////////////////////
  // Shadow reset and compare enable
  ////////////////////////////////////////

  lockstep_reset_ctrl #(
    .LockstepOffset (LockstepOffset)
  ) u_reset_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rst_shadow_no (rst_shadow_n),
    .cmp_enable_o  (cmp_enable)
  );

  ////////////////////////////////////////
  // Feeder to the shadow lane
  ////////////////////////////////////////

  // Alert test flips bit 0 of a on the shadow path only
  assign feed_in.valid = in_valid_i;
  assign feed_in.clear = in_clear_i;
  assign feed_in.a     = in_a_i ^ {{(OpW-1){1'b0}}, fault_inject_i};
  assign feed_in.b     = in_b_i;

  lockstep_delay #(
    .Depth     (LockstepOffset),
    .payload_t (lockstep_pkg::mac_op_t)
  ) u_feeder (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (feed_in),
    .data_o (feed_out)
  );

  ////////////////////////////////////////
  // MAC lanes
  ////////////////////////////////////////

  mac_op_if lane_op [NumLanes] ();

  // Main lane takes the ports directly
  assign lane_op[0].valid = in_valid_i;
  assign lane_op[0].clear = in_clear_i;
  assign lane_op[0].a     = in_a_i;
  assign lane_op[0].b     = in_b_i;

  assign lane_op[1].valid = feed_out.valid;
  assign lane_op[1].clear = feed_out.clear;
  assign lane_op[1].a     = feed_out.a;
  assign lane_op[1].b     = feed_out.b;

  assign lane_rst_n = {rst_shadow_n, rst_ni};

  for (genvar g = 0; g < NumLanes; g++) begin : gen_lane
    mac_unit u_mac (
      .clk_i  (clk_i),
      .rst_ni (lane_rst_n[g]),
      .op     (lane_op[g]),
      .res_o  (lane_res[g])
    );
  end

  ////////////////////////////////////////
  // Output compare
  ////////////////////////////////////////

  lockstep_compare #(
    .LockstepOffset (LockstepOffset)
  ) u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .main_res_i    (lane_res[0]),
    .shadow_res_i  (lane_res[1]),
    .cmp_enable_i  (cmp_enable),
    .alert_major_o (alert_major_o)
  );

  // Outputs come from the main lane
  assign acc_valid_o = lane_res[0].valid;
  assign acc_o       = lane_res[0].acc;

endmodule

`default_nettype wire

// File: src/lockstep_pkg.sv
`default_nettype none

package lockstep_pkg;

  // Datapath widths
  parameter int OperandWidth = 8;
  parameter int ProductWidth = 2 * OperandWidth;
  // Accumulator wraps modulo 2^AccWidth
  parameter int AccWidth     = 24;

  // Cycles between the main lane and the shadow lane
  parameter int DefaultLockstepOffset = 2;

  // One operation into a lane
  typedef struct packed {
    logic                    valid;
    logic                    clear;
    logic [OperandWidth-1:0] a;
    logic [OperandWidth-1:0] b;
  } mac_op_t;

  // One lane result
  typedef struct packed {
    logic                valid;
    logic [AccWidth-1:0] acc;
  } mac_res_t;

  // Multibit enable, anything other than Off reads as enabled
  parameter int MuBi4Width = 4;

  typedef logic [MuBi4Width-1:0] mubi4_t;

  parameter mubi4_t MuBi4On  = 4'b0110;
  parameter mubi4_t MuBi4Off = 4'b1001;

endpackage

`default_nettype wire

// File: src/lockstep_reset_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module lockstep_reset_ctrl #(
  parameter int LockstepOffset = lockstep_pkg::DefaultLockstepOffset
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  output logic                 rst_shadow_no,
  output lockstep_pkg::mubi4_t cmp_enable_o
);

  localparam int CntWidth = $clog2(LockstepOffset);
  localparam logic [CntWidth-1:0] CntMax = CntWidth'(LockstepOffset - 1);

  logic [CntWidth-1:0]  cnt_q;
  lockstep_pkg::mubi4_t set_d;
  lockstep_pkg::mubi4_t set_q;
  lockstep_pkg::mubi4_t enable_q;

  // Saturating counter, runs once after each system reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q < CntMax) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign set_d = (cnt_q >= CntMax) ? lockstep_pkg::MuBi4On : lockstep_pkg::MuBi4Off;

  // Release flop, then compare enable one edge later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_q    <= lockstep_pkg::MuBi4Off;
      enable_q <= lockstep_pkg::MuBi4Off;
    end else begin
      set_q    <= set_d;
      enable_q <= set_q;
    end
  end

  // Bit 0 is low for On and high for Off
  assign rst_shadow_no = ~set_q[0];
  assign cmp_enable_o  = enable_q;

  cnt_saturates_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntMax
  );

  // No checking while the shadow lane is still held
  enable_after_release_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cmp_enable_o == lockstep_pkg::MuBi4On) |-> rst_shadow_no
  );

endmodule

`default_nettype wire

// File: src/mac_op_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mac_op_if;

  logic                                 valid;
  logic                                 clear;
  logic [lockstep_pkg::OperandWidth-1:0] a;
  logic [lockstep_pkg::OperandWidth-1:0] b;

  // Source of operations
  modport driver (
    output valid,
    output clear,
    output a,
    output b
  );

  // MAC lane side
  modport lane (
    input valid,
    input clear,
    input a,
    input b
  );

endinterface

`default_nettype wire

// File: src/mac_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mac_unit (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  mac_op_if.lane                 op,
  output lockstep_pkg::mac_res_t res_o
);

  localparam int AccW  = lockstep_pkg::AccWidth;
  localparam int ProdW = lockstep_pkg::ProductWidth;

  logic [ProdW-1:0] prod;
  logic [AccW-1:0]  prod_ext;
  logic [AccW-1:0]  acc_d;
  logic [AccW-1:0]  acc_q;
  logic             valid_q;

  assign prod     = op.a * op.b;
  assign prod_ext = AccW'(prod);

  // Clear loads the product, otherwise add with wrap
  assign acc_d = op.clear ? prod_ext : acc_q + prod_ext;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= op.valid;
      if (op.valid) begin
        acc_q <= acc_d;
      end
    end
  end

  assign res_o.valid = valid_q;
  assign res_o.acc   = acc_q;

  res_valid_follows_op_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !op.valid |=> !res_o.valid
  );

endmodule

`default_nettype wire

// File: verilog.f
src/lockstep_pkg.sv
src/mac_op_if.sv
src/lockstep_delay.sv
src/lockstep_reset_ctrl.sv
src/mac_unit.sv
src/lockstep_compare.sv
src/lockstep_mac_top.sv
bench/tb_lockstep_mac.sv
